// ==== Makefile ====
# Verilator build and run of the softmc testbench
VERILATOR ?= verilator
TOP       ?= softmc_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/softmc_asserts.sv ====
`timescale 1ns/100ps

module softmc_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             app_ack,
    input logic                             mc_act_n,
    input logic                             mc_cs_n,
    input logic [softmc_dfi_pkg::row_w-1:0] mc_adr,
    input logic                             mc_rd_cas,
    input logic                             mc_wr_cas,
    input logic                             wrdata_en
);
    import softmc_dfi_pkg::*;

    logic pre_on_pins;
    assign pre_on_pins = (mc_adr[rcw_lsb +: 3] == rcw_pre);   // precharge has no strobe

    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !(app_ack && $past(app_ack))) else $error("app_ack high two cycles in a row");

    act_vs_cas: assert property (@(posedge clk) disable iff (!rst_n)
        !(!mc_act_n && (mc_rd_cas || mc_wr_cas))) else $error("act_n low with a cas strobe");

    wren_follows_wr: assert property (@(posedge clk) disable iff (!rst_n)
        wrdata_en == mc_wr_cas) else $error("wrdata_en differs from mc_wr_cas");

    cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (mc_act_n && !mc_rd_cas && !mc_wr_cas && !pre_on_pins) |-> mc_cs_n)
        else $error("cs_n low with no command on the pins");

endmodule

bind softmc_top softmc_asserts softmc_asserts_inst (
    .clk(clk), .rst_n(rst_n), .app_ack(app_ack), .mc_act_n(mc_act_n), .mc_cs_n(mc_cs_n),
    .mc_adr(mc_adr), .mc_rd_cas(mc_rd_cas), .mc_wr_cas(mc_wr_cas), .wrdata_en(wrdata_en)
);

// ==== dv/softmc_input.txt ====
// test  instr(hex)  mc_adr(hex)  kind 0 none 1 act 2 pre 3 wr 4 rd  readback byte(hex) or -
// lines with one test number form a sequence closed by op_end f0000000
1 14001234 01234 1 -
1 3402945a 1005a 3 -
1 24000000 08000 2 -
1 f0000000 00000 0 -
2 1a01abcd 1abcd 1 -
2 4a000013 14013 4 d3
2 4a0002e7 142e7 4 c7
2 50000005 00000 0 -
2 2a000000 08000 2 -
2 f0000000 00000 0 -
3 1c000ff0 00ff0 1 -
3 50000003 00000 0 -
3 3c00f3ff 103ff 3 -
3 4c000011 14011 4 71
3 60000000 00000 0 -
3 2c000000 08000 2 -
3 f0000000 00000 0 -

// ==== dv/softmc_tb.sv ====
`timescale 1ns/100ps

module softmc_tb;
    import softmc_instr_pkg::*;
    import softmc_dfi_pkg::*;

    localparam int rd_latency   = 4;              // memory side read delay in cycles
    localparam int rsp_stages   = rd_latency - 1; // plus the rddata register
    localparam int tmo_per_line = 64;
    localparam int max_lines    = 64;
    localparam int k_none = 0;                    // kind codes of the data file
    localparam int k_act  = 1;
    localparam int k_pre  = 2;
    localparam int k_wr   = 3;
    localparam int k_rd   = 4;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     app_en;
    logic [instr_w-1:0]       app_instr;
    logic                     app_ack;
    logic                     processing_iseq;
    logic                     mc_act_n;
    logic                     mc_cs_n;
    logic [row_w-1:0]         mc_adr;
    logic [ba_w-1:0]          mc_ba;
    logic [bg_w-1:0]          mc_bg;
    logic                     mc_rd_cas;
    logic                     mc_wr_cas;
    logic [dq_beat_w-1:0]     wrdata;
    logic                     wrdata_en;
    logic [dq_beat_w-1:0]     rddata = '0;
    logic                     rddata_valid = 1'b0;
    logic                     rdback_fifo_rden;
    logic                     rdback_fifo_empty;
    logic [dq_beat_w-1:0]     rdback_data;

    // vectors from the data file
    int                       n_lines;
    int                       ln_test   [max_lines];
    logic [instr_w-1:0]       ln_instr  [max_lines];
    logic [row_w-1:0]         ln_adr    [max_lines];
    int                       ln_kind   [max_lines];
    logic                     ln_has_rb [max_lines];
    logic [byte_w-1:0]        ln_rb     [max_lines];

    // commands seen on the pins
    int                       obs_kind   [$];
    logic [row_w-1:0]         obs_adr    [$];
    logic [ba_w+bg_w-1:0]     obs_bank   [$];     // {ba, bg}
    logic                     obs_wren   [$];
    logic [dq_beat_w-1:0]     obs_wrdata [$];
    int                       obs_cyc    [$];

    logic                         sending;        // sequence not sealed yet
    logic [rsp_stages-1:0]        rsp_valid = '0;
    logic [rsp_stages-1:0][7:0]   rsp_byte;
    int cycle = 0;
    int cycle_limit;
    int errors = 0;
    int checks = 0;
    int test_errs;
    int n_tests = 0;
    int n_bad = 0;
    int idx;
    int last;

    softmc_top softmc_top_inst (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // memory side read responder
    ////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        rsp_valid    <= {rsp_valid[rsp_stages-2:0], mc_rd_cas};
        rsp_byte     <= {rsp_byte[rsp_stages-2:0], {mc_bg, mc_ba, mc_adr[4:0]}};
        rddata_valid <= rsp_valid[rsp_stages-1];
        rddata       <= {(dq_beat_w / byte_w){rsp_byte[rsp_stages-1]}};
    end

    // pin monitor and cycle limit
    always @(posedge clk) begin
        if (cycle > cycle_limit) begin
            $display("run timed out after %0d cycles, limit %0d", cycle, cycle_limit);
            $display("sim failed");
            $finish;
        end else begin
            if (rst_n && !mc_cs_n) begin
                if (sending) report_failure("command on the pins before op_end was acked");
                obs_kind.push_back(!mc_act_n ? k_act : mc_wr_cas ? k_wr :
                                   mc_rd_cas ? k_rd : k_pre);
                obs_adr.push_back(mc_adr);
                obs_bank.push_back({mc_ba, mc_bg});
                obs_wren.push_back(wrdata_en);
                obs_wrdata.push_back(wrdata);
                obs_cyc.push_back(cycle);
            end
            cycle++;
        end
    end

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic check_value(input string name, input logic [dq_beat_w-1:0] expected,
                               input logic [dq_beat_w-1:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
            test_errs++;
        end
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 n;
        int                 t;
        int                 k;
        logic [instr_w-1:0] w;
        logic [row_w-1:0]   a;
        logic [byte_w-1:0]  rb;
        logic [8*128-1:0]   linebuf;
        n_lines     = 0;
        cycle_limit = 0;
        fd = $fopen("dv/softmc_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open dv/softmc_input.txt");
        end else begin
            while ($fgets(linebuf, fd) != 0) begin
                n = $sscanf(linebuf, "%d %h %h %d %h", t, w, a, k, rb);
                if (n >= 4 && n_lines < max_lines) begin   // comment lines give 0
                    ln_test[n_lines]   = t;
                    ln_instr[n_lines]  = w;
                    ln_adr[n_lines]    = a;
                    ln_kind[n_lines]   = k;
                    ln_has_rb[n_lines] = (n == 5);        // dash means no readback
                    ln_rb[n_lines]     = rb;
                    if (opcode_t'(w[op_lsb +: op_w]) == op_wait)
                        cycle_limit += int'(w[wait_lsb +: wait_w]);
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        cycle_limit += tmo_per_line * n_lines;
    endtask

    task automatic send_instr(input logic [instr_w-1:0] word);
        @(posedge clk);
        app_en    <= 1'b1;
        app_instr <= word;
        @(posedge clk);
        while (!app_ack) @(posedge clk);              // held while the queue is full
        app_en    <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // one sequence, from its first to its last data line
    ////////////////////////////////////////////////////////////////////
    task automatic run_test(input int first, input int final_ln);
        int i;
        int n_cmd;
        int cmd_i;
        int pend_wait;
        int gap;
        int busy;
        int exp_busy;
        test_errs = 0;
        n_cmd     = 0;
        busy      = 0;
        exp_busy  = final_ln - first + 1;             // one issue cycle per entry
        obs_kind.delete();
        obs_adr.delete();
        obs_bank.delete();
        obs_wren.delete();
        obs_wrdata.delete();
        obs_cyc.delete();
        sending <= 1'b1;
        for (i = first; i <= final_ln; i++) begin
            send_instr(ln_instr[i]);
            if (ln_kind[i] != k_none) n_cmd++;
            if (opcode_t'(ln_instr[i][op_lsb +: op_w]) == op_wait)
                exp_busy += int'(ln_instr[i][wait_lsb +: wait_w]);
        end
        sending <= 1'b0;                              // op_end acked
        @(negedge clk);
        while (!processing_iseq) @(negedge clk);
        while (processing_iseq) begin
            busy++;                                   // cycles the sequence runs
            @(negedge clk);
        end
        check_value("processing_iseq", dq_beat_w'(exp_busy), dq_beat_w'(busy));
        while (obs_kind.size() < n_cmd) @(negedge clk);   // pipeline drains
        check_value("cmd_count", dq_beat_w'(n_cmd), dq_beat_w'(obs_kind.size()));
        cmd_i     = 0;
        pend_wait = -1;
        for (i = first; i <= final_ln; i++) begin
            if (opcode_t'(ln_instr[i][op_lsb +: op_w]) == op_wait)
                pend_wait = int'(ln_instr[i][wait_lsb +: wait_w]);
            if (ln_kind[i] != k_none && cmd_i < obs_kind.size()) begin
                check_value("cmd_kind", dq_beat_w'(ln_kind[i]), dq_beat_w'(obs_kind[cmd_i]));
                check_value("mc_adr", dq_beat_w'(ln_adr[i]), dq_beat_w'(obs_adr[cmd_i]));
                check_value("mc_ba_bg", dq_beat_w'(ln_instr[i][bg_lsb +: ba_w + bg_w]),
                            dq_beat_w'(obs_bank[cmd_i]));
                check_value("wrdata_en", dq_beat_w'(ln_kind[i] == k_wr),
                            dq_beat_w'(obs_wren[cmd_i]));
                if (ln_kind[i] == k_wr)               // fill byte on every lane
                    check_value("wrdata", {(dq_beat_w / byte_w){ln_instr[i][pat_lsb +: 8]}},
                                obs_wrdata[cmd_i]);
                if (pend_wait >= 0 && cmd_i > 0) begin
                    gap = obs_cyc[cmd_i] - obs_cyc[cmd_i - 1];
                    if (gap < pend_wait + 1)
                        report_failure($sformatf("command %0d came %0d cycles after the last, %s",
                                       cmd_i, gap, "too soon for its wait"));
                end
                pend_wait = -1;
                cmd_i++;
            end
        end
        for (i = first; i <= final_ln; i++) begin
            if (ln_has_rb[i]) begin
                while (rdback_fifo_empty) @(negedge clk);
                check_value("rdback_data", {(dq_beat_w / byte_w){ln_rb[i]}}, rdback_data);
                @(posedge clk);
                rdback_fifo_rden <= 1'b1;
                @(posedge clk);
                rdback_fifo_rden <= 1'b0;
                @(negedge clk);
            end
        end
        check_value("rdback_fifo_empty", dq_beat_w'(1), dq_beat_w'(rdback_fifo_empty));
        n_tests++;
        if (test_errs != 0) n_bad++;
        $display("test %0d: %0d commands, %0d errors", ln_test[first], n_cmd, test_errs);
    endtask

    initial begin
        rst_n            = 1'b0;
        app_en           = 1'b0;
        app_instr        = '0;
        rdback_fifo_rden = 1'b0;
        sending          = 1'b0;
        test_errs        = 0;
        load_vectors();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // ack, busy, rd, wr, wren low; act_n, cs_n, empty high
        check_value("reset_outputs", dq_beat_w'(8'b0000_0111),
                    dq_beat_w'({app_ack, processing_iseq, mc_rd_cas, mc_wr_cas, wrdata_en,
                                mc_act_n, mc_cs_n, rdback_fifo_empty}));
        n_tests++;
        if (test_errs != 0) n_bad++;
        $display("test 0: reset values, %0d errors", test_errs);
        idx = 0;
        while (idx < n_lines) begin
            last = idx;
            while (last + 1 < n_lines && ln_test[last + 1] == ln_test[idx]) last++;
            run_test(idx, last);
            idx = last + 1;
        end
        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 n_tests, n_bad, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/softmc_instr_pkg.sv
source/softmc_dfi_pkg.sv
source/instr_queue.sv
source/cmd_sequencer.sv
source/ddr4_cmd_encoder.sv
source/rdback_fifo.sv
source/softmc_top.sv
dv/softmc_asserts.sv
dv/softmc_tb.sv

// ==== source/cmd_sequencer.sv ====
`timescale 1ns/100ps

module cmd_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        iq_valid,
    input  softmc_instr_pkg::iq_entry_t iq_head,
    output logic                        iq_pop,
    output logic                        processing_iseq,
    output softmc_dfi_pkg::dfi_cmd_t    cmd
);
    import softmc_instr_pkg::*;
    import softmc_dfi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } state_t;

    state_t            state;
    opcode_t           op;
    dfi_cmd_t          cmd_d;
    logic [wait_w-1:0] wait_d;
    logic [wait_w-1:0] wait_cnt;                  // cycles left in the gap

    assign op     = opcode_t'(iq_head.instr[op_lsb +: op_w]);
    assign wait_d = iq_head.instr[wait_lsb +: wait_w];
    assign iq_pop = (state == st_issue) && iq_valid;   // one entry per cycle

    //////////////////////////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        cmd_d         = '0;
        cmd_d.kind    = cmd_nop;
        cmd_d.ba      = iq_head.instr[ba_lsb +: ba_w];
        cmd_d.bg      = iq_head.instr[bg_lsb +: bg_w];
        cmd_d.pattern = iq_head.instr[pat_lsb +: byte_w];
        if (iq_pop) begin
            case (op)
                op_act: begin
                    cmd_d.kind = cmd_act;
                    cmd_d.addr = iq_head.instr[row_lsb +: row_w];
                end
                op_pre: cmd_d.kind = cmd_pre;
                op_wr: begin
                    cmd_d.kind             = cmd_wr;
                    cmd_d.addr[col_w-1:0]  = iq_head.instr[col_lsb +: col_w];
                end
                op_rd: begin
                    cmd_d.kind             = cmd_rd;
                    cmd_d.addr[col_w-1:0]  = iq_head.instr[col_lsb +: col_w];
                end
                default: cmd_d.kind = cmd_nop;    // wait, sealed end, unknown
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequence FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= st_idle;
            processing_iseq <= 1'b0;
            wait_cnt        <= '0;
            cmd.kind        <= cmd_nop;
        end else begin
            cmd <= cmd_d;                         // one step per cycle
            case (state)
                st_idle: begin
                    if (iq_valid) begin           // whole sequence is stored
                        state           <= st_issue;
                        processing_iseq <= 1'b1;
                    end
                end
                st_issue: begin
                    if (iq_pop && iq_head.last) begin
                        state           <= st_idle;
                        processing_iseq <= 1'b0;
                    end else if (iq_pop && op == op_wait && wait_d != '0) begin
                        wait_cnt <= wait_d;
                        state    <= st_wait;
                    end
                end
                st_wait: begin
                    wait_cnt <= wait_cnt - 1'b1;  // nop goes out meanwhile
                    if (wait_cnt == 1) state <= st_issue;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/ddr4_cmd_encoder.sv ====
`timescale 1ns/100ps

module ddr4_cmd_encoder (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  softmc_dfi_pkg::dfi_cmd_t               cmd,
    output logic                                   mc_act_n,
    output logic                                   mc_cs_n,
    output logic [softmc_dfi_pkg::row_w-1:0]       mc_adr,
    output logic [softmc_dfi_pkg::ba_w-1:0]        mc_ba,
    output logic [softmc_dfi_pkg::bg_w-1:0]        mc_bg,
    output logic                                   mc_rd_cas,
    output logic                                   mc_wr_cas,
    output logic [softmc_dfi_pkg::dq_beat_w-1:0]   wrdata,
    output logic                                   wrdata_en
);
    import softmc_dfi_pkg::*;

    logic [row_w-1:0] adr_d;

    // address pins per command kind
    always_comb begin
        adr_d = '0;
        case (cmd.kind)
            cmd_act: adr_d = cmd.addr;            // full row
            cmd_pre: adr_d[rcw_lsb +: 3] = rcw_pre;
            cmd_wr: begin
                adr_d[rcw_lsb +: 3] = rcw_wr;
                adr_d[col_w-1:0]    = cmd.addr[col_w-1:0];
            end
            cmd_rd: begin
                adr_d[rcw_lsb +: 3] = rcw_rd;
                adr_d[col_w-1:0]    = cmd.addr[col_w-1:0];
            end
            default: adr_d = '0;
        endcase
        if (cmd.kind != cmd_act) adr_d[ap_bit] = 1'b0;   // no auto precharge
    end

    //////////////////////////////////////////////////////////////////////
    // pin registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mc_act_n  <= 1'b1;
            mc_cs_n   <= 1'b1;                    // deselected
            mc_rd_cas <= 1'b0;
            mc_wr_cas <= 1'b0;
            wrdata_en <= 1'b0;
        end else begin
            mc_act_n  <= (cmd.kind != cmd_act);
            mc_cs_n   <= (cmd.kind == cmd_nop);
            mc_rd_cas <= (cmd.kind == cmd_rd);
            mc_wr_cas <= (cmd.kind == cmd_wr);
            wrdata_en <= (cmd.kind == cmd_wr);    // data with the write, no cwl
        end
    end

    always_ff @(posedge clk) begin
        mc_adr <= adr_d;
        mc_ba  <= cmd.ba;
        mc_bg  <= cmd.bg;
        wrdata <= {(dq_beat_w / byte_w){cmd.pattern}};   // fill byte across beat
    end

endmodule

// ==== source/instr_queue.sv ====
`timescale 1ns/100ps

module instr_queue (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 app_en,
    input  logic [softmc_instr_pkg::instr_w-1:0] app_instr,
    input  logic                                 iq_pop,
    output logic                                 app_ack,
    output logic                                 iq_valid,
    output softmc_instr_pkg::iq_entry_t          iq_head
);
    import softmc_instr_pkg::*;

    iq_entry_t           mem [iq_depth];
    iq_entry_t           wr_entry;
    logic [iq_ptr_w-1:0] wr_ptr;
    logic [iq_ptr_w-1:0] rd_ptr;
    logic [iq_ptr_w:0]   count;                   // stored entries
    logic [iq_ptr_w:0]   sealed_cnt;              // complete sequences waiting
    logic                full;
    logic                accept;
    logic                is_end;
    logic                seal_pop;

    assign full     = (count == (iq_ptr_w + 1)'(iq_depth));
    assign accept   = app_en && !full && !app_ack;   // ack pulse blocks a repeat
    assign is_end   = (opcode_t'(app_instr[op_lsb +: op_w]) == op_end);
    assign seal_pop = iq_pop && iq_head.last;
    assign iq_valid = (sealed_cnt != '0);
    assign iq_head  = mem[rd_ptr];

    // end marker becomes an empty word flagged last
    always_comb begin
        wr_entry.instr = app_instr;
        wr_entry.last  = 1'b0;
        if (is_end) begin
            wr_entry.instr = '0;                  // opcode 0 runs as nop
            wr_entry.last  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) mem[wr_ptr] <= wr_entry;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            app_ack    <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            sealed_cnt <= '0;
        end else begin
            app_ack <= accept;                    // one cycle after acceptance
            if (accept) wr_ptr <= wr_ptr + 1'b1;
            if (iq_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({accept, iq_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({accept && is_end, seal_pop})
                2'b10:   sealed_cnt <= sealed_cnt + 1'b1;
                2'b01:   sealed_cnt <= sealed_cnt - 1'b1;
                default: sealed_cnt <= sealed_cnt;
            endcase
        end
    end

endmodule

// ==== source/rdback_fifo.sv ====
`timescale 1ns/100ps

module rdback_fifo (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [softmc_dfi_pkg::dq_beat_w-1:0] rddata,
    input  logic                                 rddata_valid,
    input  logic                                 rdback_fifo_rden,
    output logic                                 rdback_fifo_empty,
    output logic [softmc_dfi_pkg::dq_beat_w-1:0] rdback_data
);
    import softmc_dfi_pkg::*;

    logic [dq_beat_w-1:0]    mem [rdback_depth];
    logic [rdback_ptr_w-1:0] wr_ptr;
    logic [rdback_ptr_w-1:0] rd_ptr;
    logic [rdback_ptr_w:0]   count;               // occupancy
    logic                    full;
    logic                    wr_en;
    logic                    rd_en;

    assign full              = (count == (rdback_ptr_w + 1)'(rdback_depth));
    assign rdback_fifo_empty = (count == '0);
    assign wr_en             = rddata_valid && !full;     // dram can't stall, drop
    assign rd_en             = rdback_fifo_rden && !rdback_fifo_empty;
    assign rdback_data       = mem[rd_ptr];       // show-ahead head beat

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= rddata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/softmc_dfi_pkg.sv ====
package softmc_dfi_pkg;

    localparam int row_w        = 17;
    localparam int col_w        = 10;
    localparam int ba_w         = 2;
    localparam int bg_w         = 1;
    localparam int byte_w       = 8;
    localparam int dq_beat_w    = 512;            // one user side beat
    localparam int rdback_depth = 8;
    localparam int rdback_ptr_w = $clog2(rdback_depth);

    //////////////////////////////////////////////////////////////////////
    // ddr4 address pin layout for non-activate commands
    //////////////////////////////////////////////////////////////////////
    localparam int          rcw_lsb = 14;         // ras_n cas_n we_n on 16..14
    localparam int          ap_bit  = 10;         // auto precharge, kept low
    localparam logic [2:0]  rcw_pre = 3'b010;
    localparam logic [2:0]  rcw_wr  = 3'b100;
    localparam logic [2:0]  rcw_rd  = 3'b101;

    // one-hot command kinds
    typedef enum logic [4:0] {
        cmd_nop = 5'b00001,
        cmd_act = 5'b00010,
        cmd_pre = 5'b00100,
        cmd_wr  = 5'b01000,
        cmd_rd  = 5'b10000
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t          kind;
        logic [ba_w-1:0]    ba;
        logic [bg_w-1:0]    bg;
        logic [row_w-1:0]   addr;                 // row, or column in low bits
        logic [byte_w-1:0]  pattern;              // write fill byte
    } dfi_cmd_t;

endpackage

// ==== source/softmc_instr_pkg.sv ====
package softmc_instr_pkg;

    localparam int instr_w  = 32;                 // host instruction word
    localparam int iq_depth = 16;                 // queue entries
    localparam int iq_ptr_w = $clog2(iq_depth);

    //////////////////////////////////////////////////////////////////////
    // instruction field positions
    //////////////////////////////////////////////////////////////////////
    localparam int op_w     = 4;
    localparam int op_lsb   = 28;                 // opcode in 31..28
    localparam int ba_lsb   = 26;                 // bank in 27..26
    localparam int bg_lsb   = 25;                 // bank group
    localparam int row_lsb  = 0;                  // activate row
    localparam int col_lsb  = 0;                  // rd/wr column
    localparam int pat_lsb  = 10;                 // write pattern byte
    localparam int wait_lsb = 0;
    localparam int wait_w   = 16;                 // wait gap in cycles

    // anything not listed runs as a single nop cycle
    typedef enum logic [op_w-1:0] {
        op_act  = 4'd1,
        op_pre  = 4'd2,
        op_wr   = 4'd3,
        op_rd   = 4'd4,
        op_wait = 4'd5,
        op_end  = 4'd15
    } opcode_t;

    typedef struct packed {
        logic [instr_w-1:0] instr;
        logic               last;                 // closes a sealed sequence
    } iq_entry_t;

endpackage

// ==== source/softmc_top.sv ====
`timescale 1ns/100ps

module softmc_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // host instruction port
    input  logic                                 app_en,
    input  logic [softmc_instr_pkg::instr_w-1:0] app_instr,
    output logic                                 app_ack,
    output logic                                 processing_iseq,
    // ddr4 command pins
    output logic                                 mc_act_n,
    output logic                                 mc_cs_n,
    output logic [softmc_dfi_pkg::row_w-1:0]     mc_adr,
    output logic [softmc_dfi_pkg::ba_w-1:0]      mc_ba,
    output logic [softmc_dfi_pkg::bg_w-1:0]      mc_bg,
    output logic                                 mc_rd_cas,
    output logic                                 mc_wr_cas,
    output logic [softmc_dfi_pkg::dq_beat_w-1:0] wrdata,
    output logic                                 wrdata_en,
    // read return and host readback
    input  logic [softmc_dfi_pkg::dq_beat_w-1:0] rddata,
    input  logic                                 rddata_valid,
    input  logic                                 rdback_fifo_rden,
    output logic                                 rdback_fifo_empty,
    output logic [softmc_dfi_pkg::dq_beat_w-1:0] rdback_data
);
    import softmc_instr_pkg::*;
    import softmc_dfi_pkg::*;

    logic      iq_valid;
    logic      iq_pop;
    iq_entry_t iq_head;
    dfi_cmd_t  cmd;                               // sequencer to encoder step

    instr_queue i_iq (
        .clk(clk), .rst_n(rst_n), .app_en(app_en), .app_instr(app_instr),
        .iq_pop(iq_pop), .app_ack(app_ack), .iq_valid(iq_valid), .iq_head(iq_head)
    );

    cmd_sequencer i_seq (
        .clk(clk), .rst_n(rst_n), .iq_valid(iq_valid), .iq_head(iq_head),
        .iq_pop(iq_pop), .processing_iseq(processing_iseq), .cmd(cmd)
    );

    ddr4_cmd_encoder i_enc (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .mc_act_n(mc_act_n), .mc_cs_n(mc_cs_n),
        .mc_adr(mc_adr), .mc_ba(mc_ba), .mc_bg(mc_bg), .mc_rd_cas(mc_rd_cas),
        .mc_wr_cas(mc_wr_cas), .wrdata(wrdata), .wrdata_en(wrdata_en)
    );

    rdback_fifo i_rdback (
        .clk(clk), .rst_n(rst_n), .rddata(rddata), .rddata_valid(rddata_valid),
        .rdback_fifo_rden(rdback_fifo_rden), .rdback_fifo_empty(rdback_fifo_empty),
        .rdback_data(rdback_data)
    );

endmodule
